// File: source/enc_cfg_pkg.sv
package enc_cfg_pkg;

   // ----------------------------------------
   // channel and filter configuration
   // ----------------------------------------
   localparam int NUM_CHANNELS = 4;             // encoder channels on the board
   localparam int DEBOUNCE_LEN = 3;             // equal samples before a line flips
   localparam int DB_CNT_W     = $clog2(DEBOUNCE_LEN + 1);

   // ----------------------------------------
   // datapath widths
   // ----------------------------------------
   localparam int COUNT_W  = 24;                // position counter, wraps
   localparam int PERIOD_W = 16;                // sysclk cycles between steps

   typedef logic [COUNT_W-1:0]  count_t;        // position count
   typedef logic [PERIOD_W-1:0] period_t;       // step period in sysclk cycles
   typedef logic [DB_CNT_W-1:0] db_cnt_t;       // debounce stability counter

   // channel index, sized from the channel count
   typedef logic [$clog2(NUM_CHANNELS)-1:0] chan_t;

   // all ones means stopped or unknown
   localparam period_t PERIOD_MAX = '1;

endpackage

// File: source/enc_regmap_pkg.sv
package enc_regmap_pkg;
   import enc_cfg_pkg::*;

   typedef logic [7:0]  wb_addr_t;              // word address, chan in 7..4
   typedef logic [31:0] reg_data_t;             // bus data word
   typedef logic [3:0]  reg_off_t;              // register offset field

   // address field positions
   localparam int ADR_FIELD_W  = 4;
   localparam int ADR_OFF_LSB  = 0;             // offset in bits 3..0
   localparam int ADR_CHAN_LSB = 4;             // channel in bits 7..4

   // per-channel register offsets
   localparam reg_off_t OFF_PRELOAD = 4'd0;     // r/w, low 24 bits
   localparam reg_off_t OFF_COUNT   = 4'd1;     // ro
   localparam reg_off_t OFF_PERIOD  = 4'd2;     // ro
   localparam reg_off_t OFF_STATUS  = 4'd3;     // err sticky + last dir

   localparam int STAT_ERR_BIT = 0;             // write 1 to clear
   localparam int STAT_DIR_BIT = 1;             // ro, 1 = counting up

   localparam count_t ENC_MIDRANGE = 24'h800000; // preload and counter reset
endpackage

// File: source/enc_step_if.sv
`timescale 1ns/1ps

// step bundle from one decoder to its counter and period timer
interface enc_step_if;
   logic step;        // one pulse per legal quadrature edge
   logic dir;         // 1 = up, A leads B
   logic dir_change;  // step direction differs from previous step
   logic err;         // both lines moved at once

   modport driver (output step, output dir, output dir_change, output err);

   // position counter side
   modport count (input step, input dir, input err);

   // period timer only needs the step and reversals
   modport period (input step, input dir_change);

endinterface

// File: source/enc_decode.sv
`timescale 1ns/1ps

module enc_decode import enc_cfg_pkg::*; (
   input  logic       sysclk,
   input  logic       rst_n,
   input  logic       enc_a,   // raw line, asynchronous to sysclk
   input  logic       enc_b,
   enc_step_if.driver st
);

   // bit 1 is A, bit 0 is B throughout
   logic [1:0] sync1;           // first sync stage
   logic [1:0] sync2;           // second sync stage
   logic [1:0] filt;            // debounced pair
   logic [1:0] prev;            // filtered pair one cycle back
   logic [1:0] delta;           // lines that moved
   logic       step_dir;        // direction of the current transition
   db_cnt_t    db_cnt [2];

   // ----------------------------------------
   // synchronizer and debounce
   // ----------------------------------------
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         sync1  <= '0;
         sync2  <= '0;
         filt   <= '0;
         db_cnt <= '{default: '0};
      end else begin
         sync1 <= {enc_a, enc_b};
         sync2 <= sync1;
         for (int k = 0; k < 2; k++) begin
            if (sync2[k] == filt[k]) begin
               db_cnt[k] <= '0;                 // glitch gone, start over
            end else if (db_cnt[k] == db_cnt_t'(DEBOUNCE_LEN - 1)) begin
               filt[k]   <= sync2[k];           // stable long enough
               db_cnt[k] <= '0;
            end else begin
               db_cnt[k] <= db_cnt[k] + 1'b1;
            end
         end
      end
   end

   // ----------------------------------------
   // quadrature decode
   // ----------------------------------------
   assign delta    = filt ^ prev;
   assign step_dir = prev[0] ^ filt[1];        // old B vs new A gives direction

   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         prev          <= '0;
         st.step       <= 1'b0;
         st.dir        <= 1'b0;
         st.dir_change <= 1'b0;
         st.err        <= 1'b0;
      end else begin
         prev          <= filt;
         st.step       <= (delta == 2'b01) || (delta == 2'b10);  // gray step
         st.err        <= (delta == 2'b11);                      // skipped a state
         st.dir_change <= 1'b0;
         if ((delta == 2'b01) || (delta == 2'b10)) begin
            st.dir        <= step_dir;
            st.dir_change <= (step_dir != st.dir);  // reversal
         end
      end
   end

   a_step_err_excl: assert property (@(posedge sysclk) disable iff (!rst_n)
      !(st.step && st.err))
      else $error("step and err high together");

endmodule

// File: source/enc_quad_count.sv
`timescale 1ns/1ps

module enc_quad_count import enc_cfg_pkg::*, enc_regmap_pkg::*; (
   input  logic      sysclk,
   input  logic      rst_n,
   enc_step_if.count st,
   input  logic      load,       // one-cycle pulse from the register block
   input  count_t    preload,
   output count_t    count,
   output logic      err_pulse   // err, delayed to line up with count
);

   // ----------------------------------------
   // position counter
   // ----------------------------------------
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         count <= ENC_MIDRANGE;              // start mid range so both ways work
      end else if (load) begin
         count <= preload;                   // load beats a step in the same cycle
      end else if (st.step) begin
         if (st.dir) begin
            count <= count + 1'b1;           // wraps at 2^24
         end else begin
            count <= count - 1'b1;
         end
      end
   end

   // illegal transitions leave the count alone
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         err_pulse <= 1'b0;
      end else begin
         err_pulse <= st.err;
      end
   end

   // count moves only one cycle after a step or a load
   a_count_cause: assert property (@(posedge sysclk) disable iff (!rst_n)
      (!$past(st.step) && !$past(load)) |-> $stable(count))
      else $error("count changed without step or load");

endmodule

// File: source/enc_period.sv
`timescale 1ns/1ps

module enc_period import enc_cfg_pkg::*; (
   input  logic       sysclk,
   input  logic       rst_n,
   enc_step_if.period st,
   output period_t    period    // cycles between the last two steps
);

   period_t cyc_cnt;   // cycles since last step, sticks at max

   // ----------------------------------------
   // free-running step interval counter
   // ----------------------------------------
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         cyc_cnt <= PERIOD_MAX;             // no step seen yet
      end else if (st.step) begin
         cyc_cnt <= period_t'(1);           // the step cycle counts as one
      end else if (cyc_cnt != PERIOD_MAX) begin
         cyc_cnt <= cyc_cnt + 1'b1;
      end
   end

   // ----------------------------------------
   // period capture
   // ----------------------------------------
   // a reversal gives no usable interval,
   // so the period reads as unknown until the next step
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         period <= PERIOD_MAX;
      end else if (st.step) begin
         if (st.dir_change) begin
            period <= PERIOD_MAX;           // direction flipped
         end else begin
            period <= cyc_cnt;              // latch, may already be saturated
         end
      end
   end

endmodule

// File: source/enc_reg_ctrl.sv
`timescale 1ns/1ps

module enc_reg_ctrl import enc_cfg_pkg::*, enc_regmap_pkg::*; (
   input  logic                    sysclk,
   input  logic                    rst_n,
   // wishbone classic slave
   input  logic                    wb_cyc,
   input  logic                    wb_stb,
   input  logic                    wb_we,
   input  wb_addr_t                wb_adr,
   input  reg_data_t               wb_wdata,
   output reg_data_t               wb_rdata,
   output logic                    wb_ack,
   // per-channel results
   input  count_t                  counts  [NUM_CHANNELS],
   input  period_t                 periods [NUM_CHANNELS],
   input  logic [NUM_CHANNELS-1:0] err_pulse,
   input  logic [NUM_CHANNELS-1:0] dir,
   // preload to the counters
   output logic [NUM_CHANNELS-1:0] load,
   output count_t                  preload [NUM_CHANNELS]
);

   logic                    acc;       // first cycle of a bus access
   logic                    wr;
   logic [ADR_FIELD_W-1:0]  adr_chan;  // full field, may be out of range
   reg_off_t                adr_off;
   logic                    chan_ok;
   chan_t                   chan;
   logic [NUM_CHANNELS-1:0] sel;       // write hits this channel
   logic [NUM_CHANNELS-1:0] err_flag;  // sticky
   reg_data_t               rd_mux;

   // ----------------------------------------
   // address decode
   // ----------------------------------------
   assign acc      = wb_cyc && wb_stb && !wb_ack;   // ack low, so one ack per access
   assign wr       = acc && wb_we;
   assign adr_chan = wb_adr[ADR_CHAN_LSB +: ADR_FIELD_W];
   assign adr_off  = wb_adr[ADR_OFF_LSB +: ADR_FIELD_W];
   assign chan_ok  = (adr_chan < NUM_CHANNELS);
   assign chan     = chan_t'(adr_chan);

   always_comb begin
      for (int i = 0; i < NUM_CHANNELS; i++) begin
         sel[i] = wr && chan_ok && (chan == chan_t'(i));
      end
   end

   // ----------------------------------------
   // control registers
   // ----------------------------------------
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         wb_ack   <= 1'b0;
         load     <= '0;
         err_flag <= '0;
         preload  <= '{default: ENC_MIDRANGE};
      end else begin
         wb_ack <= acc;                              // fixed single wait state
         for (int i = 0; i < NUM_CHANNELS; i++) begin
            load[i] <= sel[i] && (adr_off == OFF_PRELOAD);  // counter loads next edge
            if (sel[i] && (adr_off == OFF_PRELOAD)) begin
               preload[i] <= wb_wdata[COUNT_W-1:0];
            end
            // a new error wins over a clear in the same cycle
            if (err_pulse[i]) begin
               err_flag[i] <= 1'b1;
            end else if (sel[i] && (adr_off == OFF_STATUS) && wb_wdata[STAT_ERR_BIT]) begin
               err_flag[i] <= 1'b0;
            end
         end
      end
   end

   // read mux, zero extended
   always_comb begin
      rd_mux = '0;
      if (chan_ok) begin
         case (adr_off)
            OFF_PRELOAD: rd_mux = reg_data_t'(preload[chan]);
            OFF_COUNT:   rd_mux = reg_data_t'(counts[chan]);
            OFF_PERIOD:  rd_mux = reg_data_t'(periods[chan]);
            OFF_STATUS: begin
               rd_mux[STAT_ERR_BIT] = err_flag[chan];
               rd_mux[STAT_DIR_BIT] = dir[chan];
            end
            default:     rd_mux = '0;       // unused offsets read zero
         endcase
      end
   end

   always_ff @(posedge sysclk) begin
      if (acc) begin
         wb_rdata <= rd_mux;                 // valid together with ack
      end
   end

   a_ack_after_stb: assert property (@(posedge sysclk) disable iff (!rst_n)
      wb_ack |-> $past(wb_cyc && wb_stb))
      else $error("ack without a preceding strobe");

endmodule

// File: source/enc_ctrl_top.sv
`timescale 1ns/1ps

module enc_ctrl_top import enc_cfg_pkg::*, enc_regmap_pkg::*; (
   input  logic                    sysclk,
   input  logic                    rst_n,
   input  logic [NUM_CHANNELS-1:0] enc_a,   // raw quadrature lines
   input  logic [NUM_CHANNELS-1:0] enc_b,
   // wishbone classic slave
   input  logic                    wb_cyc,
   input  logic                    wb_stb,
   input  logic                    wb_we,
   input  wb_addr_t                wb_adr,
   input  reg_data_t               wb_wdata,
   output reg_data_t               wb_rdata,
   output logic                    wb_ack
);

   // ----------------------------------------
   // per-channel result buses
   // ----------------------------------------
   count_t                  counts  [NUM_CHANNELS];
   period_t                 periods [NUM_CHANNELS];
   count_t                  preload [NUM_CHANNELS];
   logic [NUM_CHANNELS-1:0] load;
   logic [NUM_CHANNELS-1:0] err_pulse;
   logic [NUM_CHANNELS-1:0] dir;

   for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
      enc_step_if u_st ();

      enc_decode u_enc_decode (
         .sysclk (sysclk),
         .rst_n  (rst_n),
         .enc_a  (enc_a[i]),
         .enc_b  (enc_b[i]),
         .st     (u_st)
      );

      enc_quad_count u_enc_quad_count (
         .sysclk    (sysclk),
         .rst_n     (rst_n),
         .st        (u_st),
         .load      (load[i]),
         .preload   (preload[i]),
         .count     (counts[i]),
         .err_pulse (err_pulse[i])
      );

      enc_period u_enc_period (
         .sysclk (sysclk),
         .rst_n  (rst_n),
         .st     (u_st),
         .period (periods[i])
      );

      assign dir[i] = u_st.dir;   // last direction for status
   end

   enc_reg_ctrl u_enc_reg_ctrl (
      .sysclk    (sysclk),
      .rst_n     (rst_n),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_wdata  (wb_wdata),
      .wb_rdata  (wb_rdata),
      .wb_ack    (wb_ack),
      .counts    (counts),
      .periods   (periods),
      .err_pulse (err_pulse),
      .dir       (dir),
      .load      (load),
      .preload   (preload)
   );

endmodule

// File: test/enc_ctrl_tb.sv
`timescale 1ns/1ps

module enc_ctrl_tb import enc_cfg_pkg::*, enc_regmap_pkg::*; ();

   localparam int    ACK_TIMEOUT = 20;                    // cycles allowed for wb_ack
   localparam int    SETTLE      = 10;                    // sync + debounce + decode + count
   localparam string STIM_FILE   = "test/enc_stim.txt";

   logic                    sysclk = 1'b0;
   logic                    rst_n;
   logic [NUM_CHANNELS-1:0] enc_a;
   logic [NUM_CHANNELS-1:0] enc_b;
   logic                    wb_cyc;
   logic                    wb_stb;
   logic                    wb_we;
   wb_addr_t                wb_adr;
   reg_data_t               wb_wdata;
   reg_data_t               wb_rdata;
   logic                    wb_ack;

   logic [1:0] phase [NUM_CHANNELS];   // quadrature state driven on each channel
   int         n_checks;

   always #50 sysclk = ~sysclk;        // 100 ns sysclk

   enc_ctrl_top u_enc_ctrl_top (
      .sysclk   (sysclk),
      .rst_n    (rst_n),
      .enc_a    (enc_a),
      .enc_b    (enc_b),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_wdata (wb_wdata),
      .wb_rdata (wb_rdata),
      .wb_ack   (wb_ack)
   );

   // ----------------------------------------
   // error exit and typed compares
   // ----------------------------------------
   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_count(input string name, input count_t exp, input count_t act);
      n_checks++;
      if (act !== exp) begin
         abort_run($sformatf("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act));
      end
   endtask

   task automatic check_period(input string name, input period_t exp, input period_t act);
      n_checks++;
      if (act !== exp) begin
         abort_run($sformatf("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act));
      end
   endtask

   task automatic check_status(input string name, input reg_data_t exp, input reg_data_t act);
      n_checks++;   // whole word, so unused status bits must read zero
      if (act !== exp) begin
         abort_run($sformatf("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act));
      end
   endtask

   task automatic check_data(input string name, input reg_data_t exp, input reg_data_t act);
      n_checks++;
      if (act !== exp) begin
         abort_run($sformatf("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act));
      end
   endtask

   // ----------------------------------------
   // timing helpers and encoder lines
   // ----------------------------------------
   task automatic idle(input int n);
      for (int k = 0; k < n; k++) begin
         @(negedge sysclk);              // every drive happens just after this
      end
   endtask

   // gray order, A leads B when moving up
   function automatic logic [1:0] phase_to_ab(input logic [1:0] ph);
      case (ph)
         2'd0:    return 2'b00;
         2'd1:    return 2'b10;
         2'd2:    return 2'b11;
         default: return 2'b01;
      endcase
   endfunction

   task automatic set_lines(input int ch);
      logic [1:0] ab;
      ab        = phase_to_ab(phase[ch]);
      enc_a[ch] = ab[1];
      enc_b[ch] = ab[0];
   endtask

   task automatic move_encoder(input int ch, input int steps, input int hold);
      int n;
      n = (steps < 0) ? -steps : steps;
      if (hold < DEBOUNCE_LEN) begin
         abort_run("motion hold is shorter than the debounce filter");
      end
      for (int k = 0; k < n; k++) begin
         idle(1);
         phase[ch] = (steps > 0) ? phase[ch] + 2'd1 : phase[ch] - 2'd1;
         set_lines(ch);
         idle(hold - 1);                 // edges exactly hold cycles apart
      end
      idle(SETTLE);
   endtask

   // both lines flip in the same cycle
   task automatic force_error(input int ch);
      idle(1);
      phase[ch] = phase[ch] + 2'd2;
      set_lines(ch);
      idle(SETTLE);
   endtask

   // ----------------------------------------
   // wishbone master
   // ----------------------------------------
   task automatic bus_cycle(input logic we, input int ch, input int off,
                            input reg_data_t wdata, output reg_data_t rdata);
      int waited;
      idle(1 + ($urandom % 4));           // random idle gap
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = wb_addr_t'((ch << ADR_CHAN_LSB) | off);
      wb_wdata = wdata;
      waited   = 0;
      do begin
         @(negedge sysclk);
         waited++;
      end while (!wb_ack && waited < ACK_TIMEOUT);
      if (!wb_ack) begin
         abort_run($sformatf("wb_ack never came for channel %0d offset %0d", ch, off));
      end
      rdata  = wb_rdata;                 // valid while ack is high
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic write_reg(input int ch, input int off, input reg_data_t data);
      reg_data_t unused;
      bus_cycle(1'b1, ch, off, data, unused);
   endtask

   task automatic read_reg(input int ch, input int off, input reg_data_t exp);
      reg_data_t rd;
      string     name;
      bus_cycle(1'b0, ch, off, '0, rd);
      name = $sformatf("wb_rdata ch%0d off%0d", ch, off);
      if (ch >= NUM_CHANNELS) begin
         check_data(name, exp, rd);      // out of range reads zero
      end else begin
         case (reg_off_t'(off))
            OFF_PRELOAD, OFF_COUNT: begin
               check_count(name, count_t'(exp), count_t'(rd));
               check_data({name, " upper bits"}, '0, rd >> COUNT_W);   // zero extended
            end
            OFF_PERIOD: begin
               check_period(name, period_t'(exp), period_t'(rd));
               check_data({name, " upper bits"}, '0, rd >> PERIOD_W);
            end
            OFF_STATUS:             check_status(name, exp, rd);
            default:                check_data(name, exp, rd);
         endcase
      end
   endtask

   // ----------------------------------------
   // stimulus file interpreter
   // ----------------------------------------
   initial begin
      int        fd;
      int        n_args;
      int        ch;
      int        arg1;
      int        arg2;
      reg_data_t val;
      string     line;
      string     rest;
      rst_n    = 1'b0;
      enc_a    = '0;
      enc_b    = '0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_wdata = '0;
      phase    = '{default: 2'd0};
      n_checks = 0;
      void'($urandom(64));               // one seed for the whole run
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         abort_run("cannot open the stimulus file test/enc_stim.txt");
      end
      idle(5);                           // five cycles in reset
      rst_n = 1'b1;
      idle(2);
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 2 || line[0] == "#") begin
            continue;                    // blank or comment
         end
         rest = line.substr(1, line.len() - 1);
         case (line[0])
            "W", "R": begin
               n_args = $sscanf(rest, "%d %d %h", ch, arg1, val);
               if (n_args != 3) abort_run($sformatf("bad stimulus line: %s", line));
               if (line[0] == "W") write_reg(ch, arg1, val);
               else read_reg(ch, arg1, val);
            end
            "M": begin
               n_args = $sscanf(rest, "%d %d %d", ch, arg1, arg2);
               if (n_args != 3) abort_run($sformatf("bad stimulus line: %s", line));
               move_encoder(ch, arg1, arg2);
            end
            "E": begin
               n_args = $sscanf(rest, "%d", ch);
               if (n_args != 1) abort_run($sformatf("bad stimulus line: %s", line));
               force_error(ch);
            end
            default: abort_run($sformatf("unknown stimulus command: %s", line));
         endcase
      end
      $fclose(fd);
      if (n_checks == 0) begin
         abort_run("the stimulus file held no checks");
      end else begin
         $display("Simulation completed successfully");
         $finish;
      end
   end

endmodule

// File: test/enc_stim.txt
# W chan off data | R chan off expected  (chan and off decimal, data and expected hex)
# M chan steps hold (signed quarter steps, sysclk cycles per phase) | E chan (A and B flip)
R 0 0 800000
R 0 1 800000
R 0 2 ffff
R 0 3 0
R 1 0 800000
R 1 1 800000
R 1 2 ffff
R 1 3 0
R 2 0 800000
R 2 1 800000
R 2 2 ffff
R 2 3 0
R 3 0 800000
R 3 1 800000
R 3 2 ffff
R 3 3 0
# up 10 then down 4 on channel 1, others untouched
M 1 10 12
R 1 3 2
R 1 2 c
M 1 -4 12
R 1 1 800006
R 1 3 0
R 1 2 c
R 0 1 800000
R 2 1 800000
# period and reversal on channel 2
M 2 6 20
R 2 2 14
M 2 -1 20
R 2 2 ffff
R 2 1 800005
M 2 -3 9
R 2 2 9
R 2 1 800002
# preload keeps the low 24 bits, count wraps both ways
W 3 0 ab123456
R 3 0 123456
R 3 1 123456
M 3 2 10
R 3 1 123458
W 3 0 fffffe
R 3 1 fffffe
M 3 3 10
R 3 1 1
M 3 -2 10
R 3 1 ffffff
R 3 0 fffffe
# illegal double change on channel 0
E 0
R 0 3 1
R 0 1 800000
W 0 3 1
R 0 3 0
M 0 2 8
R 0 1 800002
R 0 3 2
# channels at or above the channel count
R 4 1 0
R 7 0 0
R 15 3 0
W 5 0 ffffff
R 1 0 800000

// File: all.f
source/enc_cfg_pkg.sv
source/enc_regmap_pkg.sv
source/enc_step_if.sv
source/enc_decode.sv
source/enc_quad_count.sv
source/enc_period.sv
source/enc_reg_ctrl.sv
source/enc_ctrl_top.sv
test/enc_ctrl_tb.sv

// File: Makefile
# Verilator build and run for the quadrature encoder front end

VERILATOR ?= verilator
TOP       ?= enc_ctrl_tb
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard source/*.sv test/*.sv)
PASS := Simulation completed successfully

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@grep -q "$(PASS)" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
